// File: hdl/hps_io_pkg.sv
////////////////////////////////////////////////////////////
// host command receiver package
// command codes, field widths and shared types for the
// user channel and the file download channel
////////////////////////////////////////////////////////////
package hps_io_pkg;

	// field widths
	localparam int HOST_WORD_W = 16;
	localparam int WORD_IDX_W  = 5;
	localparam int JOY_W       = 32;
	localparam int STATUS_W    = 64;
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 8;
	localparam int STAT_REQ_W  = 4;

	typedef logic [HOST_WORD_W-1:0]  host_word_t;
	typedef logic [WORD_IDX_W-1:0]   word_idx_t;
	typedef logic [JOY_W-1:0]        joy_t;
	typedef logic [STATUS_W-1:0]     status_t;
	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [IOCTL_DATA_W-1:0] ioctl_data_t;
	typedef logic [STAT_REQ_W-1:0]   stat_req_cnt_t;

	////////////////////////////////////////////////////////////
	// user channel commands
	localparam host_word_t CMD_CFG        = 16'h01;
	localparam host_word_t CMD_JOY0       = 16'h02;
	localparam host_word_t CMD_JOY1       = 16'h03;
	localparam host_word_t CMD_JOY_RAW    = 16'h0F;
	localparam host_word_t CMD_STATUS     = 16'h1E;
	localparam host_word_t CMD_STATUS_REQ = 16'h29;
	localparam host_word_t CMD_MENUMASK   = 16'h2E;

	// file channel commands
	localparam host_word_t FIO_FILE_TX     = 16'h53;
	localparam host_word_t FIO_FILE_TX_DAT = 16'h54;
	localparam host_word_t FIO_FILE_INDEX  = 16'h55;

	// marker in the upper nibble of the request readback
	localparam stat_req_cnt_t STAT_REQ_TAG = 4'hA;

	// bit positions in the configuration word
	localparam int CFG_SCANDBL_BIT = 4;
	localparam int CFG_DIRECT_BIT  = 10;

	typedef enum logic [0:0] {DL_IDLE = 1'b0, DL_ACTIVE = 1'b1} dl_state_t;

endpackage

// File: hdl/host_frame_if.sv
////////////////////////////////////////////////////////////
// host frame interface
// decoded host words from the receiver to the handlers
////////////////////////////////////////////////////////////
interface host_frame_if import hps_io_pkg::*; ();

	// one pulse per accepted word
	logic       word_stb;
	// word came in on fp_enable
	logic       file_chan;
	word_idx_t  word_idx;
	host_word_t cmd;
	host_word_t word;
	// active enable has dropped
	logic       frame_end;

	modport rx (
		output word_stb, file_chan, word_idx,
		output cmd, word, frame_end
	);

	modport sink (
		input word_stb, file_chan, word_idx,
		input cmd, word, frame_end
	);

endinterface

// File: hdl/host_frame_rx.sv
////////////////////////////////////////////////////////////
// host frame receiver
// registers strobed host words, counts the word index,
// latches the frame command and flags the frame end
////////////////////////////////////////////////////////////
module host_frame_rx import hps_io_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_strobe,
	input  logic       io_enable,
	input  logic       fp_enable,
	input  host_word_t io_din,
	host_frame_if.rx   frame
);

	logic      en_any;
	logic      en_d;
	logic      accept;
	word_idx_t word_cnt;

	// only one enable is high at a time
	assign en_any = io_enable | fp_enable;
	assign accept = io_strobe & en_any;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			en_d            <= 1'b0;
			frame.frame_end <= 1'b0;
			word_cnt        <= '0;
		end else begin
			en_d            <= en_any;
			frame.frame_end <= en_d & ~en_any;

			// index restarts whenever no frame is open
			if (!en_any) begin
				word_cnt <= '0;
			end else if (accept && !(&word_cnt)) begin
				word_cnt <= word_cnt + word_idx_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// word register

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frame.word_stb  <= 1'b0;
			frame.file_chan <= 1'b0;
			frame.word_idx  <= '0;
			frame.cmd       <= '0;
			frame.word      <= '0;
		end else begin
			frame.word_stb <= accept;
			if (accept) begin
				frame.file_chan <= fp_enable;
				frame.word_idx  <= word_cnt;
				frame.word      <= io_din;
				// first word of the frame is the command
				if (word_cnt == '0) begin
					frame.cmd <= io_din;
				end
			end
		end
	end

endmodule

// File: hdl/user_io_regs.sv
////////////////////////////////////////////////////////////
// user channel registers
// configuration word, two joysticks and the status
// register written by host argument words
////////////////////////////////////////////////////////////
module user_io_regs import hps_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	host_frame_if.sink  frame,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output joy_t        joystick_0,
	output joy_t        joystick_1,
	output status_t     status
);

	host_word_t cfg;
	logic       arg_stb;

	// argument words of a user frame
	assign arg_stb = frame.word_stb & ~frame.file_chan & (frame.word_idx != '0);

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[CFG_SCANDBL_BIT];
	assign direct_video       = cfg[CFG_DIRECT_BIT];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (arg_stb) begin
			case (frame.cmd)
				CMD_CFG: begin
					cfg <= frame.word;
				end

				// low half first and then high half
				CMD_JOY0: begin
					if (frame.word_idx == 5'd1) begin
						joystick_0[15:0] <= frame.word;
					end else if (frame.word_idx == 5'd2) begin
						joystick_0[31:16] <= frame.word;
					end
				end

				CMD_JOY1: begin
					if (frame.word_idx == 5'd1) begin
						joystick_1[15:0] <= frame.word;
					end else if (frame.word_idx == 5'd2) begin
						joystick_1[31:16] <= frame.word;
					end
				end

				// 64-bit status with the least significant word first
				CMD_STATUS: begin
					case (frame.word_idx)
						5'd1: status[15:0]  <= frame.word;
						5'd2: status[31:16] <= frame.word;
						5'd3: status[47:32] <= frame.word;
						5'd4: status[63:48] <= frame.word;
						default: begin
							// extra words are dropped
						end
					endcase
				end

				default: begin
				end
			endcase
		end
	end

endmodule

// File: hdl/file_loader.sv
////////////////////////////////////////////////////////////
// file download loader
// tracks the download state and turns file data words
// into byte write strobes with a running address
////////////////////////////////////////////////////////////
module file_loader import hps_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	host_frame_if.sink  frame,
	output logic        ioctl_download,
	output host_word_t  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output ioctl_data_t ioctl_dout
);

	dl_state_t   dl_state;
	ioctl_addr_t addr;
	logic        arg_stb;

	// argument words of a file frame
	assign arg_stb = frame.word_stb & frame.file_chan & (frame.word_idx != '0);

	assign ioctl_download = (dl_state == DL_ACTIVE);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_state    <= DL_IDLE;
			addr        <= '0;
			ioctl_index <= '0;
			ioctl_wr    <= 1'b0;
			ioctl_addr  <= '0;
			ioctl_dout  <= '0;
		end else begin
			ioctl_wr <= 1'b0;

			if (arg_stb) begin
				case (frame.cmd)
					FIO_FILE_INDEX: begin
						if (frame.word_idx == 5'd1) begin
							ioctl_index <= frame.word;
						end
					end

					////////////////////////////////////////////////////////////
					// transfer control and start address
					FIO_FILE_TX: begin
						case (frame.word_idx)
							5'd1: begin
								if (frame.word[7:0] != 8'h00) begin
									dl_state <= DL_ACTIVE;
									addr     <= '0;
								end else begin
									// park the output on the next free address
									if (dl_state == DL_ACTIVE) begin
										ioctl_addr <= addr;
									end
									dl_state <= DL_IDLE;
								end
							end
							5'd2: begin
								addr[15:0]       <= frame.word;
								ioctl_addr[15:0] <= frame.word;
							end
							5'd3: begin
								addr[26:16]       <= frame.word[10:0];
								ioctl_addr[26:16] <= frame.word[10:0];
							end
							default: begin
							end
						endcase
					end

					// data bytes only while a download runs
					FIO_FILE_TX_DAT: begin
						if (dl_state == DL_ACTIVE) begin
							ioctl_wr   <= 1'b1;
							ioctl_addr <= addr;
							ioctl_dout <= frame.word[7:0];
							addr       <= addr + ioctl_addr_t'(1);
						end
					end

					default: begin
					end
				endcase
			end
		end
	end

endmodule

// File: hdl/host_readback.sv
////////////////////////////////////////////////////////////
// host readback
// captures core status-change requests and builds the
// read data word returned on each user channel strobe
////////////////////////////////////////////////////////////
module host_readback import hps_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	host_frame_if.sink  frame,
	input  host_word_t  joy_raw,
	input  status_t     status_in,
	input  logic        status_set,
	input  host_word_t  status_menumask,
	output host_word_t  io_dout
);

	logic          status_set_d;
	stat_req_cnt_t stat_req_cnt;
	status_t       status_req;

	// request counter and status snapshot on status_set rising edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			stat_req_cnt <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				stat_req_cnt <= stat_req_cnt + stat_req_cnt_t'(1);
				status_req   <= status_in;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read data

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			io_dout <= '0;
		end else if (frame.frame_end) begin
			io_dout <= '0;
		end else if (frame.word_stb) begin
			io_dout <= '0;
			if (!frame.file_chan) begin
				case (frame.cmd)
					CMD_STATUS_REQ: begin
						case (frame.word_idx)
							5'd0: io_dout <= {8'h00, STAT_REQ_TAG, stat_req_cnt};
							5'd1: io_dout <= status_req[15:0];
							5'd2: io_dout <= status_req[31:16];
							5'd3: io_dout <= status_req[47:32];
							5'd4: io_dout <= status_req[63:48];
							default: io_dout <= '0;
						endcase
					end
					CMD_MENUMASK: begin
						if (frame.word_idx == 5'd1) begin
							io_dout <= status_menumask;
						end
					end
					// raw bits on every argument word
					CMD_JOY_RAW: begin
						if (frame.word_idx != '0) begin
							io_dout <= joy_raw;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

// File: hdl/hps_io_top.sv
////////////////////////////////////////////////////////////
// host command receiver top level
// frame receiver, user registers, file loader and
// readback joined over the frame interface
////////////////////////////////////////////////////////////
module hps_io_top import hps_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,

	// host bus
	input  logic        io_strobe,
	input  logic        io_enable,
	input  logic        fp_enable,
	input  host_word_t  io_din,
	output host_word_t  io_dout,

	// user channel
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic        direct_video,
	output joy_t        joystick_0,
	output joy_t        joystick_1,
	output status_t     status,
	input  host_word_t  joy_raw,
	input  status_t     status_in,
	input  logic        status_set,
	input  host_word_t  status_menumask,

	// file download
	output logic        ioctl_download,
	output host_word_t  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output ioctl_data_t ioctl_dout
);

	host_frame_if frame_bus ();

	host_frame_rx i_host_frame_rx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_din    (io_din),
		.frame     (frame_bus.rx)
	);

	user_io_regs i_user_io_regs (
		.clk_sys(clk_sys), .rst_n(rst_n), .frame(frame_bus.sink),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status)
	);

	file_loader i_file_loader (
		.clk_sys(clk_sys), .rst_n(rst_n), .frame(frame_bus.sink),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout)
	);

	host_readback i_host_readback (
		.clk_sys(clk_sys), .rst_n(rst_n), .frame(frame_bus.sink),
		.joy_raw(joy_raw), .status_in(status_in), .status_set(status_set),
		.status_menumask(status_menumask), .io_dout(io_dout)
	);

endmodule

// File: dv/tb_hps_io.sv
////////////////////////////////////////////////////////////
// host command receiver testbench
// directed tests of the user registers, the readback path
// and the file download over the strobed host bus
////////////////////////////////////////////////////////////
module tb_hps_io import hps_io_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 4000;

	logic        clk_sys;
	logic        rst_n;
	logic        io_strobe;
	logic        io_enable;
	logic        fp_enable;
	host_word_t  io_din;
	host_word_t  io_dout;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic        direct_video;
	joy_t        joystick_0;
	joy_t        joystick_1;
	status_t     status;
	host_word_t  joy_raw;
	status_t     status_in;
	logic        status_set;
	host_word_t  status_menumask;
	logic        ioctl_download;
	host_word_t  ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;

	int          check_cnt = 0;
	int          error_cnt = 0;
	int          cycle_cnt = 0;
	int          wr_cnt = 0;
	host_word_t  rd_word;
	// bytes seen on the write strobe by address
	ioctl_data_t wr_bytes [ioctl_addr_t];

	hps_io_top i_hps_io_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	always @(posedge clk_sys) begin
		if (ioctl_wr) begin
			wr_bytes[ioctl_addr] = ioctl_dout;
			wr_cnt = wr_cnt + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// host bus and check helpers

	// wait n edges and step past the last one
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic open_frame(input logic file_chan);
		io_enable = ~file_chan;
		fp_enable = file_chan;
		tick(1);
	endtask

	// one word every 4 cycles with read data taken 3 cycles after the strobe
	task automatic send_word(input host_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		tick(1);
		io_strobe = 1'b0;
		tick(2);
		rd_word = io_dout;
		tick(1);
	endtask

	task automatic close_frame();
		io_enable = 1'b0;
		fp_enable = 1'b0;
		tick(4);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests

	task automatic test_config();
		host_word_t cfg;
		cfg = host_word_t'($urandom);
		open_frame(1'b0);
		send_word(CMD_CFG);
		send_word(cfg);
		close_frame();
		check_value("buttons", 64'(buttons), 64'(cfg[1:0]));
		check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(cfg[4]));
		check_value("direct_video", 64'(direct_video), 64'(cfg[10]));
	endtask

	task automatic test_joy_status();
		joy_t       joy0;
		joy_t       joy1;
		host_word_t st_w [5];
		status_t    st_exp;
		joy0 = $urandom;
		joy1 = $urandom;
		open_frame(1'b0);
		send_word(CMD_JOY0);
		send_word(joy0[15:0]);
		send_word(joy0[31:16]);
		close_frame();
		open_frame(1'b0);
		send_word(CMD_JOY1);
		send_word(joy1[15:0]);
		send_word(joy1[31:16]);
		close_frame();
		check_value("joystick_0", 64'(joystick_0), 64'(joy0));
		check_value("joystick_1", 64'(joystick_1), 64'(joy1));
		foreach (st_w[i]) st_w[i] = host_word_t'($urandom);
		st_exp = {st_w[3], st_w[2], st_w[1], st_w[0]};
		open_frame(1'b0);
		send_word(CMD_STATUS);
		for (int i = 0; i < 4; i++) send_word(st_w[i]);
		check_value("status after four words", status, st_exp);
		// fifth argument must be dropped
		send_word(st_w[4]);
		close_frame();
		check_value("status after fifth word", status, st_exp);
	endtask

	task automatic test_status_req();
		status_t snap;
		// each pulse spans two edges so only its rising edge may count
		repeat (3) begin
			snap       = {$urandom, $urandom};
			status_in  = snap;
			status_set = 1'b1;
			tick(2);
			status_set = 1'b0;
			tick(2);
		end
		status_in = ~snap;
		open_frame(1'b0);
		send_word(CMD_STATUS_REQ);
		check_value("request word", 64'(rd_word), 64'({8'h00, STAT_REQ_TAG, 4'd3}));
		for (int i = 0; i < 4; i++) begin
			send_word('0);
			check_value("captured status word", 64'(rd_word), 64'(snap[16*i +: 16]));
		end
		close_frame();
		check_value("io_dout after frame end", 64'(io_dout), 64'd0);
	endtask

	task automatic test_readback();
		status_menumask = host_word_t'($urandom);
		joy_raw         = host_word_t'($urandom);
		open_frame(1'b0);
		send_word(CMD_MENUMASK);
		check_value("menumask command word", 64'(rd_word), 64'd0);
		send_word('0);
		check_value("menumask", 64'(rd_word), 64'(status_menumask));
		close_frame();
		open_frame(1'b0);
		send_word(CMD_JOY_RAW);
		repeat (2) begin
			send_word('0);
			check_value("joy_raw", 64'(rd_word), 64'(joy_raw));
		end
		close_frame();
	endtask

	task automatic test_download();
		host_word_t  idx;
		ioctl_data_t bytes [6];
		ioctl_addr_t a;
		idx = host_word_t'($urandom);
		foreach (bytes[i]) bytes[i] = ioctl_data_t'($urandom);
		open_frame(1'b1);
		send_word(FIO_FILE_INDEX);
		send_word(idx);
		close_frame();
		check_value("ioctl_index", 64'(ioctl_index), 64'(idx));
		// start with address 100
		open_frame(1'b1);
		send_word(FIO_FILE_TX);
		send_word(16'h0001);
		send_word(16'd100);
		send_word(16'd0);
		close_frame();
		check_value("ioctl_download after start", 64'(ioctl_download), 64'd1);
		open_frame(1'b1);
		send_word(FIO_FILE_TX_DAT);
		foreach (bytes[i]) send_word({8'h00, bytes[i]});
		close_frame();
		check_value("ioctl_download during data", 64'(ioctl_download), 64'd1);
		open_frame(1'b1);
		send_word(FIO_FILE_TX);
		send_word(16'h0000);
		close_frame();
		check_value("ioctl_download after stop", 64'(ioctl_download), 64'd0);
		check_value("write count", 64'(wr_cnt), 64'd6);
		for (int i = 0; i < 6; i++) begin
			a = ioctl_addr_t'(100 + i);
			if (wr_bytes.exists(a)) begin
				check_value("written byte", 64'(wr_bytes[a]), 64'(bytes[i]));
			end else begin
				error_cnt++;
				$display("no write was seen at address %0d", a);
			end
		end
		check_value("ioctl_addr after stop", 64'(ioctl_addr), 64'd106);
	endtask

	task automatic test_ignored_data();
		int wr_before;
		wr_before = wr_cnt;
		open_frame(1'b1);
		send_word(FIO_FILE_TX_DAT);
		repeat (3) send_word(host_word_t'($urandom));
		close_frame();
		check_value("writes while idle", 64'(wr_cnt), 64'(wr_before));
	endtask

	initial begin
		void'($urandom(32'h331));
		rst_n           = 1'b0;
		io_strobe       = 1'b0;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_din          = '0;
		joy_raw         = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		tick(2);
		test_config();
		test_joy_status();
		test_status_req();
		test_readback();
		test_download();
		test_ignored_data();
		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
hdl/hps_io_pkg.sv
hdl/host_frame_if.sv
hdl/host_frame_rx.sv
hdl/user_io_regs.sv
hdl/file_loader.sv
hdl/host_readback.sv
hdl/hps_io_top.sv
dv/tb_hps_io.sv

// File: run_sim.sh
#!/bin/sh
# build and run the host command receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_hps_io

verilator --binary --timing -f compile.f --top-module tb_hps_io \
	--Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation run returned status $run_status"
	exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
